// File: adc_capture_tests.txt
# columns: ch0_sample ch1_sample sync_tag capture_full, all in hex
# capture_full is held high for the whole output of that word
a5f00f 5a0ff0 01 0
800001 7ffffe 02 0
123456 fedcba 03 1
000000 ffffff 04 0
c3c3c3 3c3c3c 05 0
deadbe 0badc0 06 1
654321 abcdef 07 1
f0f0f0 0f0f0f 08 0
13579b 2468ac 09 0

// File: adc_pkg.sv
package adc_pkg;

   // one conversion result as it comes off the ADC, MSB first
   typedef logic [23:0] sample_t;

   // sync tag copied from the DAC side into the low byte of every output word
   typedef logic [7:0] tag_t;

   // word presented to the FIFO write port, sample left-justified above the tag
   typedef logic [31:0] fifo_word_t;

   // position inside one MCLK period, so adc_cycles may not exceed 32
   typedef logic [4:0] cycle_t;

   // bits still to read for the word being acquired
   typedef logic [4:0] bit_index_t;

   // the sequencer walks start through wait once per MCLK period
   typedef enum logic [2:0] {
      st_reset   = 3'd0,
      st_start   = 3'd1,
      st_convert = 3'd2,
      st_sync    = 3'd3,
      st_acquire = 3'd4,
      st_wait    = 3'd5
   } seq_state_t;

   // outer mode, tracks where we are in the full-word read
   typedef enum logic [1:0] {
      mode_acquire = 2'd0,
      mode_wait    = 2'd1,
      mode_sync    = 2'd2
   } read_mode_t;

   // one stage of the output register chain, valid marks a word that must leave this cycle
   typedef struct packed {
      logic    valid;
      sample_t sample;
   } chain_link_t;

   // decoded sequencer state plus the registered shift strobe
   typedef struct packed {
      logic is_reset;
      logic is_start;
      logic is_acquire;
      logic shift_ena;
   } sequencer_ctrl_t;

endpackage

// File: channel_chain.sv
`timescale 1ns/1ps

module channel_chain
   import adc_pkg::*;
#(
   parameter int adc_channels = 2
) (
   input  logic                    capture_clk,
   input  sequencer_ctrl_t         ctrl,
   input  logic                    load_ena,
   input  logic [adc_channels-1:0] adc_sdoa,
   input  tag_t                    sync_tag,
   input  logic                    capture_full,
   output fifo_word_t              capture_data,
   output logic                    capture_en
);

   // links[0] is the head, the far end feeds zeros so the chain empties behind the words
   chain_link_t links [adc_channels+1];

   assign links[adc_channels] = '0;

   // channel 0 is written first and the others move down toward it
   for (genvar chan = 0; chan < adc_channels; chan++) begin : g_chan
      channel_shifter u_shifter (
         .capture_clk (capture_clk),
         .clear       (ctrl.is_reset),
         .in_bit      (adc_sdoa[chan]),
         .shift_ena   (ctrl.shift_ena),
         .load_ena    (load_ena),
         .chain_in    (links[chan+1]),
         .chain_out   (links[chan])
      );
   end

   always_ff @(posedge capture_clk) begin
      capture_data <= {links[0].sample, sync_tag};
   end

   // a valid head is written or lost, there is no retry and no stall
   always_ff @(posedge capture_clk) begin
      if (ctrl.is_reset) begin
         capture_en <= 1'b0;
      end else begin
         capture_en <= links[0].valid && !capture_full;
      end
   end

endmodule

// File: channel_shifter.sv
`timescale 1ns/1ps

module channel_shifter
   import adc_pkg::*;
(
   input  logic        capture_clk,
   input  logic        clear,
   input  logic        in_bit,
   input  logic        shift_ena,
   input  logic        load_ena,
   input  chain_link_t chain_in,
   output chain_link_t chain_out
);

   // serial input side, filled MSB first across several MCLK periods
   sample_t shift_reg;
   logic    out_valid;
   sample_t out_sample;

   always_ff @(posedge capture_clk) begin
      if (shift_ena) begin
         shift_reg <= {shift_reg[$bits(sample_t)-2:0], in_bit};
      end
   end

   // the output register double buffers the word so the next read can overlap the drain
   always_ff @(posedge capture_clk) begin
      if (clear) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= load_ena ? 1'b1 : chain_in.valid;
      end
   end

   // on other cycles the word steps one place toward channel 0
   always_ff @(posedge capture_clk) begin
      out_sample <= load_ena ? shift_reg : chain_in.sample;
   end

   assign chain_out = '{valid: out_valid, sample: out_sample};

endmodule

// File: conversion_sequencer.sv
`timescale 1ns/1ps

module conversion_sequencer
   import adc_pkg::*;
#(
   parameter int adc_cycles     = 32,
   parameter int convert_cycles = 12,
   parameter int acquire_nbits  = 4
) (
   input  logic            capture_clk,
   input  logic            external_reset,
   input  read_mode_t      mode,
   output sequencer_ctrl_t ctrl,
   output logic            adc_mclk,
   output logic            adc_sync,
   output logic            adc_scka
);

   // cycle positions where the state machine moves on, all relative to start
   localparam cycle_t convert_last = cycle_t'(convert_cycles - 1);
   // the first bit slot after convert is kept for the SYNC pulse
   localparam cycle_t sync_last    = cycle_t'(convert_cycles + 1);
   // each SCKA bit takes two capture_clk cycles
   localparam cycle_t acquire_last = cycle_t'(convert_cycles + 1 + 2 * acquire_nbits);
   localparam cycle_t period_last  = cycle_t'(adc_cycles - 1);

   seq_state_t state;
   cycle_t     cycle;
   logic       convert_end;
   logic       sync_end;
   logic       acquire_end;
   logic       wait_end;
   logic       scka_slot;
   // set when the current adc_sync level comes from reset rather than a periodic pulse
   logic       reset_sync;
   logic       shift_ena_q;

   assign convert_end = (cycle == convert_last);
   assign sync_end    = (cycle == sync_last);
   assign acquire_end = (cycle == acquire_last);
   assign wait_end    = (cycle == period_last);

   // SCKA is high in odd cycles, so the next edge raises it when this cycle is even
   assign scka_slot = ~cycle[0];

   assign ctrl.is_reset   = (state == st_reset);
   assign ctrl.is_start   = (state == st_start);
   assign ctrl.is_acquire = (state == st_acquire);
   assign ctrl.shift_ena  = shift_ena_q;

   // free-running position in the MCLK period, state lags it by one cycle
   always_ff @(posedge capture_clk) begin
      if (external_reset || ctrl.is_reset || wait_end) begin
         cycle <= '0;
      end else begin
         cycle <= cycle + cycle_t'(1);
      end
   end

   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         state <= st_reset;
      end else begin
         case (state)
            // enter through wait so the first start lands on cycle zero
            st_reset:   state <= st_wait;
            st_start:   state <= st_convert;
            st_convert: begin
               if (convert_end) begin
                  // a finished word skips the sync slot and the acquire window
                  state <= (mode == mode_wait) ? st_wait : st_sync;
               end
            end
            st_sync: begin
               if (sync_end) begin
                  state <= st_acquire;
               end
            end
            st_acquire: begin
               if (acquire_end) begin
                  // with no spare cycles the next conversion follows directly
                  state <= wait_end ? st_start : st_wait;
               end
            end
            st_wait: begin
               if (wait_end) begin
                  state <= st_start;
               end
            end
            default:    state <= st_reset;
         endcase
      end
   end

   // every ADC pin is a flop output so no runt pulses reach the converters
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         adc_mclk    <= 1'b0;
         adc_scka    <= 1'b0;
         adc_sync    <= 1'b1;
         reset_sync  <= 1'b1;
         shift_ena_q <= 1'b0;
      end else begin
         adc_mclk <= (state == st_start) || (state == st_convert);
         // in sync mode the MSB is already on SDOA, so the first SCKA pulse is dropped
         adc_scka <= ctrl.is_acquire && (mode != mode_sync) && scka_slot;
         // SYNC is held through reset and pulsed once at the start of each word
         adc_sync <= ctrl.is_reset || ((state == st_sync) && (mode == mode_sync) && scka_slot);
         reset_sync <= ctrl.is_reset;
         // the ADC moves its data on the falling clock edge, so sample one cycle later
         shift_ena_q <= adc_scka || (adc_sync && !reset_sync);
      end
   end

endmodule

// File: multi_adc_capture.sv
`timescale 1ns/1ps

module multi_adc_capture
   import adc_pkg::*;
#(
   parameter int adc_channels   = 2,
   parameter int adc_cycles     = 32,
   parameter int convert_cycles = 12,
   parameter int acquire_nbits  = 4,
   parameter int adc_decimate   = 8
) (
   input  logic                    capture_clk,
   input  logic                    external_reset,
   input  logic [adc_channels-1:0] adc_sdoa,
   input  tag_t                    sync_tag,
   input  logic                    capture_full,
   output fifo_word_t              capture_data,
   output logic                    capture_en,
   output logic                    adc_mclk,
   output logic                    adc_sync,
   output logic                    adc_scka
);

   sequencer_ctrl_t ctrl;
   read_mode_t      mode;
   logic            load_ena;

   // one sequencer clocks all converters, only the data paths are per channel
   conversion_sequencer #(
      .adc_cycles     (adc_cycles),
      .convert_cycles (convert_cycles),
      .acquire_nbits  (acquire_nbits)
   ) seq0 (
      .capture_clk    (capture_clk),
      .external_reset (external_reset),
      .mode           (mode),
      .ctrl           (ctrl),
      .adc_mclk       (adc_mclk),
      .adc_sync       (adc_sync),
      .adc_scka       (adc_scka)
   );

   word_tracker #(
      .adc_decimate (adc_decimate)
   ) trk0 (
      .capture_clk (capture_clk),
      .ctrl        (ctrl),
      .mode        (mode),
      .load_ena    (load_ena)
   );

   channel_chain #(
      .adc_channels (adc_channels)
   ) chain0 (
      .capture_clk  (capture_clk),
      .ctrl         (ctrl),
      .load_ena     (load_ena),
      .adc_sdoa     (adc_sdoa),
      .sync_tag     (sync_tag),
      .capture_full (capture_full),
      .capture_data (capture_data),
      .capture_en   (capture_en)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_multi_adc_capture -f src.f -o tb_sim > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 || cat build.log sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: src.f
adc_pkg.sv
conversion_sequencer.sv
word_tracker.sv
channel_shifter.sv
channel_chain.sv
multi_adc_capture.sv
tb_multi_adc_capture_sva.sv
tb_multi_adc_capture.sv

// File: tb_multi_adc_capture.sv
`timescale 1ns/1ps

module tb_multi_adc_capture
   import adc_pkg::*;
();

   localparam int adc_channels   = 2;
   localparam int adc_cycles     = 32;
   localparam int convert_cycles = 12;
   localparam int acquire_nbits  = 4;
   localparam int adc_decimate   = 8;
   localparam int clk_period     = 20;
   localparam int drive_delay    = 2;
   localparam int reset_cycles   = 8;
   localparam int max_lines      = 64;

   logic                    capture_clk;
   logic                    external_reset;
   logic [adc_channels-1:0] adc_sdoa;
   tag_t                    sync_tag;
   logic                    capture_full;
   fifo_word_t              capture_data;
   logic                    capture_en;
   logic                    adc_mclk;
   logic                    adc_sync;
   logic                    adc_scka;

   // one entry per data line, the file has one sample column per channel
   sample_t line_sample [max_lines][adc_channels];
   tag_t    line_tag [max_lines];
   logic    line_full [max_lines];
   int      num_lines = 0;
   bit      file_loaded = 1'b0;
   bit      run_active = 1'b0;
   int      fail_count = 0;

   // ADC model state and output tracking
   sample_t cur_sample [adc_channels];
   int      lines_started = 0;
   int      cur_line = 0;
   int      bit_idx = 0;
   int      burst_pos = 0;
   int      words_seen = 0;
   int      sync_len = 0;
   bit      reset_sync_seen = 1'b0;
   int      mclk_len = 0;
   int      mclk_rises = 0;
   int      burst_mark = 0;
   int      last_burst_line = -1;
   logic    prev_sync = 1'b1;
   logic    prev_scka = 1'b0;
   logic    prev_mclk = 1'b0;

   initial capture_clk = 1'b0;
   always #(clk_period / 2) capture_clk = ~capture_clk;

   multi_adc_capture #(
      .adc_channels   (adc_channels),
      .adc_cycles     (adc_cycles),
      .convert_cycles (convert_cycles),
      .acquire_nbits  (acquire_nbits),
      .adc_decimate   (adc_decimate)
   ) dut0 (
      .capture_clk    (capture_clk),
      .external_reset (external_reset),
      .adc_sdoa       (adc_sdoa),
      .sync_tag       (sync_tag),
      .capture_full   (capture_full),
      .capture_data   (capture_data),
      .capture_en     (capture_en),
      .adc_mclk       (adc_mclk),
      .adc_sync       (adc_sync),
      .adc_scka       (adc_scka)
   );

   task automatic stop_run();
      fail_count++;
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0d ns: %s", $time, msg);
      stop_run();
   endtask

   task automatic report_problem(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   task automatic read_tests();
      int      fd;
      int      fields;
      string   text;
      sample_t s0;
      sample_t s1;
      tag_t    tg;
      logic [3:0] fl;
      fd = $fopen("adc_capture_tests.txt", "r");
      if (fd == 0) begin
         report_problem("could not open adc_capture_tests.txt");
      end
      while ($fgets(text, fd) != 0) begin
         // comment lines start with a hash, blank lines hold only the newline
         if (text.len() > 1 && text.getc(0) != "#") begin
            fields = $sscanf(text, "%h %h %h %h", s0, s1, tg, fl);
            if (fields != 4 || num_lines >= max_lines) begin
               report_problem($sformatf("test file line is malformed: %s", text));
            end
            line_sample[num_lines][0] = s0;
            line_sample[num_lines][1] = s1;
            line_tag[num_lines]       = tg;
            line_full[num_lines]      = fl[0];
            num_lines++;
         end
      end
      $fclose(fd);
      if (num_lines == 0) begin
         report_problem("test file holds no words");
      end
   endtask

   // each FIFO word is the sample left-justified above the sync tag
   function automatic fifo_word_t expected_word(input int line, input int chan);
      return {line_sample[line][chan], line_tag[line]};
   endfunction

   function automatic int expected_word_count();
      int total;
      total = 0;
      for (int i = 0; i < num_lines; i++) begin
         if (!line_full[i]) begin
            total += adc_channels;
         end
      end
      return total;
   endfunction

   task automatic check_idle(input string when_txt);
      assert (!adc_mclk && !adc_scka && !capture_en && adc_sync)
         else report_mismatch($sformatf("mclk %b scka %b capture_en %b sync %b %s",
                                        adc_mclk, adc_scka, capture_en, adc_sync, when_txt));
   endtask

   // a SYNC falling edge hands the ADC a new conversion, MSB already on SDOA
   task automatic start_next_line();
      int prev;
      prev = lines_started - 1;
      if (prev >= 0 && prev < num_lines) begin
         assert (line_full[prev] || burst_pos == adc_channels)
            else report_mismatch($sformatf("line %0d left %0d of %0d words",
                                           prev, burst_pos, adc_channels));
      end
      cur_line  = lines_started;
      burst_pos = 0;
      bit_idx   = $bits(sample_t) - 1;
      for (int ch = 0; ch < adc_channels; ch++) begin
         cur_sample[ch] = (cur_line < num_lines) ? line_sample[cur_line][ch] : '0;
         adc_sdoa[ch]   = cur_sample[ch][bit_idx];
      end
      // tag and full flag stay put until the next word starts
      sync_tag     = (cur_line < num_lines) ? line_tag[cur_line] : '0;
      capture_full = (cur_line < num_lines) ? line_full[cur_line] : 1'b0;
      lines_started++;
   endtask

   task automatic present_next_bit();
      assert (bit_idx > 0) else report_problem("SCKA clocked past the LSB of a word");
      bit_idx--;
      for (int ch = 0; ch < adc_channels; ch++) begin
         adc_sdoa[ch] = cur_sample[ch][bit_idx];
      end
   endtask

   task automatic check_capture();
      fifo_word_t expected;
      int         rises;
      if (capture_en) begin
         assert (lines_started > 0 && cur_line < num_lines)
            else report_problem("capture_en came with no word outstanding");
         assert (!line_full[cur_line])
            else report_mismatch($sformatf("capture_en for line %0d while FIFO full", cur_line));
         assert (burst_pos < adc_channels)
            else report_mismatch($sformatf("line %0d gave more words than channels", cur_line));
         if (burst_pos == 0) begin
            // spacing counts whole decimation groups, skipped full lines included
            if (last_burst_line >= 0) begin
               rises = mclk_rises - burst_mark;
               assert (rises == adc_decimate * (cur_line - last_burst_line))
                  else report_mismatch($sformatf("%0d MCLK rises between lines %0d and %0d",
                                                 rises, last_burst_line, cur_line));
            end
            last_burst_line = cur_line;
            burst_mark      = mclk_rises;
         end
         expected = expected_word(cur_line, burst_pos);
         assert (capture_data === expected)
            else report_mismatch($sformatf("line %0d channel %0d data %h expected %h",
                                           cur_line, burst_pos, capture_data, expected));
         burst_pos++;
         words_seen++;
      end else begin
         assert (burst_pos == 0 || burst_pos == adc_channels)
            else report_mismatch($sformatf("burst of line %0d broke after %0d words",
                                           cur_line, burst_pos));
      end
   endtask

   // all pins are read a little after the edge, where they are settled
   task automatic sample_cycle();
      if (adc_sync) begin
         sync_len++;
      end else if (prev_sync) begin
         // the first fall ends the reset level and carries no word
         if (reset_sync_seen) begin
            assert (sync_len == 1)
               else report_mismatch($sformatf("SYNC pulse %0d cycles wide", sync_len));
            start_next_line();
         end
         reset_sync_seen = 1'b1;
         sync_len        = 0;
      end
      if (prev_scka && !adc_scka) begin
         present_next_bit();
      end
      assert (!(adc_sync && adc_scka)) else report_mismatch("SYNC and SCKA high together");
      assert (!(adc_scka && !prev_scka && adc_mclk))
         else report_mismatch("SCKA rose while MCLK was high");
      if (adc_mclk) begin
         if (!prev_mclk) begin
            mclk_rises++;
         end
         mclk_len++;
      end else if (prev_mclk) begin
         assert (mclk_len == convert_cycles)
            else report_mismatch($sformatf("MCLK high for %0d cycles", mclk_len));
         mclk_len = 0;
      end
      check_capture();
      prev_sync = adc_sync;
      prev_scka = adc_scka;
      prev_mclk = adc_mclk;
   endtask

   always @(posedge capture_clk) begin
      #(drive_delay);
      if (run_active) begin
         sample_cycle();
      end
   end

   initial begin
      external_reset = 1'b1;
      adc_sdoa       = '0;
      sync_tag       = '0;
      capture_full   = 1'b0;
      read_tests();
      file_loaded = 1'b1;
      // outputs settle on the first reset edge and are checked from the second on
      for (int cyc = 1; cyc <= reset_cycles; cyc++) begin
         @(posedge capture_clk);
         if (cyc == reset_cycles) begin
            run_active = 1'b1;
         end
         #(drive_delay);
         if (cyc > 1) begin
            check_idle("during reset");
         end
      end
      external_reset = 1'b0;
      @(posedge capture_clk);
      #(drive_delay);
      check_idle("in the first cycle after reset");
      // the SYNC after the last line closes the check of that line
      wait (lines_started > num_lines);
      assert (words_seen == expected_word_count())
         else report_mismatch($sformatf("%0d words written, expected %0d",
                                        words_seen, expected_word_count()));
      if (fail_count == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("TEST RESULT: FAIL");
         $fatal(1, "checks failed");
      end
   end

   // two spare decimation groups cover the reset and the closing SYNC
   initial begin
      int limit_ns;
      wait (file_loaded);
      limit_ns = (num_lines + 2) * adc_decimate * adc_cycles * clk_period
               + reset_cycles * clk_period + 4000;
      #(limit_ns);
      $display("timeout: the run did not finish within %0d ns", limit_ns);
      $display("TEST RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: tb_multi_adc_capture_sva.sv
`timescale 1ns/1ps

module adc_pin_checks (
   input logic capture_clk,
   input logic external_reset,
   input logic adc_mclk,
   input logic adc_sync,
   input logic adc_scka,
   input logic capture_en,
   input logic capture_full
);

   // the converter must see no serial clock edge while MCLK is converting
   scka_outside_convert: assert property (
      @(posedge capture_clk) disable iff (external_reset)
      $rose(adc_scka) |-> !adc_mclk
   ) else $error("adc_scka rose while adc_mclk was high");

   // SYNC takes the place of a bit clock so the two never overlap
   sync_scka_exclusive: assert property (
      @(posedge capture_clk) disable iff (external_reset)
      !(adc_sync && adc_scka)
   ) else $error("adc_sync and adc_scka were high together");

   // capture_en is a register, so it answers to the full flag one cycle earlier
   no_write_when_full: assert property (
      @(posedge capture_clk) disable iff (external_reset)
      capture_en |-> !$past(capture_full)
   ) else $error("capture_en issued while capture_full was high");

endmodule

bind multi_adc_capture adc_pin_checks pin_checks0 (
   .capture_clk    (capture_clk),
   .external_reset (external_reset),
   .adc_mclk       (adc_mclk),
   .adc_sync       (adc_sync),
   .adc_scka       (adc_scka),
   .capture_en     (capture_en),
   .capture_full   (capture_full)
);

// File: word_tracker.sv
`timescale 1ns/1ps

module word_tracker
   import adc_pkg::*;
#(
   parameter int adc_decimate = 8
) (
   input  logic            capture_clk,
   input  sequencer_ctrl_t ctrl,
   output read_mode_t      mode,
   output logic            load_ena
);

   localparam int dec_w = (adc_decimate > 1) ? $clog2(adc_decimate) : 1;
   localparam bit_index_t last_bit = bit_index_t'($bits(sample_t) - 1);

   // counts MCLK periods down to zero, a new filtered word is ready at the next start
   logic [dec_w-1:0] decimate_count;
   // bits still to take for the current word, zero means the LSB comes next
   bit_index_t       bits_left;
   logic             period_wrap;

   assign period_wrap = ctrl.is_start && (decimate_count == '0);

   always_ff @(posedge capture_clk) begin
      if (ctrl.is_reset) begin
         // the first start after reset is a wrap, so the first group is a full period long
         decimate_count <= '0;
         // sync first so the first word starts aligned to the filter
         mode           <= mode_sync;
      end else if (ctrl.is_start) begin
         if (decimate_count == '0) begin
            decimate_count <= dec_w'(adc_decimate - 1);
            mode           <= mode_sync;
         end else begin
            decimate_count <= decimate_count - 1'b1;
            // a load can coincide with start when the period has no wait cycles
            if (load_ena) begin
               mode <= mode_wait;
            end
         end
      end else if (load_ena) begin
         mode <= mode_wait;
      end else if (ctrl.is_acquire && (mode == mode_sync)) begin
         // sync mode lasts into the first acquire slot to suppress that SCKA pulse
         mode <= mode_acquire;
      end
   end

   // the bit count restarts at every decimation wrap so it cannot drift from the ADC
   always_ff @(posedge capture_clk) begin
      if (ctrl.is_reset || period_wrap) begin
         bits_left <= last_bit;
         load_ena  <= 1'b0;
      end else if (ctrl.shift_ena) begin
         if (bits_left == '0) begin
            bits_left <= last_bit;
            load_ena  <= 1'b1;
         end else begin
            bits_left <= bits_left - bit_index_t'(1);
            load_ena  <= 1'b0;
         end
      end else begin
         load_ena <= 1'b0;
      end
   end

endmodule
